//--- include/multiFifo_settings.svh
// Multi-FIFO sizing
`ifndef MULTIFIFO_SETTINGS_SVH
`define MULTIFIFO_SETTINGS_SVH

// Number of logical FIFOs sharing the storage
// Must be at least two for the arbiter to have any choice to make
`define MF_NUM_FIFOS 4

// Number of entries in the shared data RAM
// The same number sets the pointer RAM size, the free list size and the
// number of push credits the sender holds after reset
`define MF_DEPTH 16

// Payload width in bits
`define MF_WIDTH 32

`endif

//--- rtl/multiFifoPkg.sv
// Multi-FIFO user types
`include "multiFifo_settings.svh"

package multiFifoPkg;

  // Binary number of a logical FIFO as carried with each push
  typedef logic [$clog2(`MF_NUM_FIFOS)-1:0] fifoIdT;

  // One payload word as pushed and popped
  typedef logic [`MF_WIDTH-1:0] dataT;

  // Item count of one FIFO
  // One extra code is needed so a FIFO that owns every entry can be counted
  typedef logic [$clog2(`MF_DEPTH+1)-1:0] countT;

  // One bit per logical FIFO
  // Used for pop valids and readies, empties, arbiter requests and grants
  typedef logic [`MF_NUM_FIFOS-1:0] fifoVecT;

endpackage

//--- rtl/multiFifoMemPkg.sv
// Multi-FIFO storage types
`include "multiFifo_settings.svh"

package multiFifoMemPkg;

  // Index of one entry in the shared data RAM
  // The free list, the staging buffers and the link words all carry it
  typedef logic [$clog2(`MF_DEPTH)-1:0] addrT;

  // Word held in the pointer RAM
  // Entry N of the pointer RAM names the entry that follows N in its list
  typedef addrT ptrT;

endpackage

//--- rtl/syncRam.sv
// Simple dual-port RAM
`timescale 1ns/1ns

module syncRam #(
  // Word type stored in every entry
  parameter type wordT = logic,
  // Number of entries
  parameter int depth = 16,
  localparam int addrW = (depth > 1) ? $clog2(depth) : 1
) (
  input  logic             clk,
  input  logic             wrEn,
  input  logic [addrW-1:0] wrAddr,
  input  wordT             wrData,
  input  logic             rdEn,
  input  logic [addrW-1:0] rdAddr,
  output wordT             rdData
);

  // Storage array
  // Contents are only meaningful after an entry has been written
  wordT mem [depth];

  // Write port
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Read port with one cycle of latency
  // A read of the entry being written in the same cycle returns the old word
  // rdData holds its value on cycles without a read
  always_ff @(posedge clk) begin
    if (rdEn) begin
      rdData <= mem[rdAddr];
    end
  end

endmodule

//--- rtl/freeList.sv
// Free entry queue
`timescale 1ns/1ns

module freeList #(
  // Number of RAM entries managed
  parameter int depth = 16
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  alloc,
  input  logic                  dealloc,
  input  multiFifoMemPkg::addrT deallocAddr,
  output multiFifoMemPkg::addrT allocAddr,
  output logic                  pushCredit
);

  // Circular queue of free addresses with read and write pointers
  multiFifoMemPkg::addrT slot [depth];
  multiFifoMemPkg::addrT rdPtr;
  multiFifoMemPkg::addrT wrPtr;
  multiFifoPkg::countT   freeCount;

  // Advance a queue pointer with wrap at the last slot
  function automatic multiFifoMemPkg::addrT wrapInc(multiFifoMemPkg::addrT p);
    if (p == multiFifoMemPkg::addrT'(depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // The head of the queue is always offered to the controller
  assign allocAddr = slot[rdPtr];

  // Every entry starts out free, in address order
  // Freed entries are appended at the write pointer
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < depth; i++) begin
        slot[i] <= multiFifoMemPkg::addrT'(i);
      end
    end else if (dealloc) begin
      slot[wrPtr] <= deallocAddr;
    end
  end

  // Pointer and count bookkeeping
  // The queue is full after reset so both pointers start at slot zero
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rdPtr      <= '0;
      wrPtr      <= '0;
      freeCount  <= multiFifoPkg::countT'(depth);
      pushCredit <= 1'b0;
    end else begin
      if (alloc) begin
        rdPtr <= wrapInc(rdPtr);
      end
      if (dealloc) begin
        wrPtr <= wrapInc(wrPtr);
      end
      freeCount  <= freeCount - multiFifoPkg::countT'(alloc) + multiFifoPkg::countT'(dealloc);
      // One credit goes back to the sender the cycle after each free
      pushCredit <= dealloc;
    end
  end

  // The sender must hold a credit for every push it makes
  allocNotEmptyA: assert property (@(posedge clk) disable iff (!rstN)
    alloc |-> freeCount != '0);

  // An entry can only be freed after it was handed out
  noOverflowA: assert property (@(posedge clk) disable iff (!rstN)
    dealloc |-> freeCount < multiFifoPkg::countT'(depth));

endmodule

//--- rtl/rrArbiter.sv
// Round-robin arbiter
`timescale 1ns/1ns

module rrArbiter #(
  // Number of requesters
  parameter int numReq = 4,
  localparam int idxW = (numReq > 1) ? $clog2(numReq) : 1
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic [numReq-1:0] request,
  input  logic              update,
  output logic [numReq-1:0] grant
);

  // Index of the most recent winner
  logic [idxW-1:0] lastIdx;
  // Index and presence of this cycle's winner
  logic [idxW-1:0] winIdx;
  logic            found;

  // Search starts at the requester just after the last winner
  // The last winner itself is checked last so it wins only when alone
  always_comb begin
    int cand;
    grant  = '0;
    winIdx = lastIdx;
    found  = 1'b0;
    for (int i = 1; i <= numReq; i++) begin
      cand = (int'(lastIdx) + i) % numReq;
      if (!found && request[cand]) begin
        found       = 1'b1;
        winIdx      = idxW'(cand);
        grant[cand] = 1'b1;
      end
    end
  end

  // Priority moves only when the grant is actually used
  // Starting at the last index gives requester zero the first turn
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      lastIdx <= idxW'(numReq - 1);
    end else if (update && found) begin
      lastIdx <= winIdx;
    end
  end

endmodule

//--- rtl/stagingBuffer.sv
// Pop staging buffer
`timescale 1ns/1ns

module stagingBuffer (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  fillValid,
  input  multiFifoPkg::dataT    fillData,
  input  multiFifoMemPkg::addrT fillAddr,
  input  logic                  popReady,
  output logic                  popValid,
  output multiFifoPkg::dataT    popData,
  output logic                  free,
  output logic                  dealloc,
  output multiFifoMemPkg::addrT deallocAddr
);

  // Held item and the RAM entry it came from
  multiFifoPkg::dataT    heldData;
  multiFifoMemPkg::addrT heldAddr;

  // Occupancy flag
  // A fill sets it and a pop clears it, and a fill wins when both happen
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      popValid <= 1'b0;
    end else if (fillValid) begin
      popValid <= 1'b1;
    end else if (dealloc) begin
      popValid <= 1'b0;
    end
  end

  // Payload capture
  always_ff @(posedge clk) begin
    if (fillValid) begin
      heldData <= fillData;
      heldAddr <= fillAddr;
    end
  end

  assign popData     = heldData;
  // Room next cycle if empty now or leaving now
  assign free        = !popValid || popReady;
  // The RAM entry goes back to the free list on the handshake
  assign dealloc     = popValid && popReady;
  assign deallocAddr = heldAddr;

  // The controller only reads for a buffer that will have room
  fillOnlyWhenFreeA: assert property (@(posedge clk) disable iff (!rstN)
    fillValid |-> free);

endmodule

//--- rtl/multiFifoCtrl.sv
// Linked-list controller
`timescale 1ns/1ns

module multiFifoCtrl (
  input  logic                    clk,
  input  logic                    rstN,
  // Push side from the sender
  input  logic                    pushValid,
  input  multiFifoPkg::fifoIdT    pushFifoId,
  input  multiFifoPkg::dataT      pushData,
  // Free list
  input  multiFifoMemPkg::addrT   allocAddr,
  output logic                    alloc,
  // Data RAM write port
  output logic                    dataWrEn,
  output multiFifoMemPkg::addrT   dataWrAddr,
  output multiFifoPkg::dataT      dataWrData,
  // Pointer RAM write port
  output logic                    ptrWrEn,
  output multiFifoMemPkg::addrT   ptrWrAddr,
  output multiFifoMemPkg::ptrT    ptrWrData,
  // Shared read port of both RAMs
  output logic                    rdEn,
  output multiFifoMemPkg::addrT   rdAddr,
  input  multiFifoMemPkg::ptrT    ptrRdData,
  // External arbiter
  output multiFifoPkg::fifoVecT   arbRequest,
  input  multiFifoPkg::fifoVecT   arbGrant,
  output logic                    arbUpdate,
  // Staging buffers
  input  multiFifoPkg::fifoVecT   bufFree,
  input  multiFifoPkg::fifoVecT   bufEmpty,
  output multiFifoPkg::fifoVecT   fillValid,
  output multiFifoMemPkg::addrT   fillAddr,
  output multiFifoPkg::fifoVecT   popEmpty
);

  localparam int numFifos = $bits(multiFifoPkg::fifoVecT);

  // Per-FIFO list state
  // count holds the entries still in RAM whose read has not been issued
  multiFifoMemPkg::addrT head [numFifos];
  multiFifoMemPkg::addrT tail [numFifos];
  multiFifoPkg::countT   count [numFifos];

  // The one read in flight, returning next cycle
  logic                  rdPending;
  multiFifoPkg::fifoIdT  rdFifo;
  multiFifoMemPkg::addrT rdEntry;
  logic                  rdHasNext;

  // Decoded events of this cycle
  multiFifoPkg::fifoIdT  grantId;
  multiFifoPkg::fifoVecT pushVec;
  multiFifoPkg::fifoVecT readVec;
  logic                  pushToEmpty;

  always_comb begin
    grantId = '0;
    for (int f = 0; f < numFifos; f++) begin
      if (arbGrant[f]) begin
        grantId = multiFifoPkg::fifoIdT'(f);
      end
      pushVec[f]    = pushValid && (pushFifoId == multiFifoPkg::fifoIdT'(f));
      readVec[f]    = arbGrant[f];
      fillValid[f]  = rdPending && (rdFifo == multiFifoPkg::fifoIdT'(f));
      // No second read for a FIFO until its head pointer has come back
      arbRequest[f] = (count[f] != '0) && bufFree[f] && !fillValid[f];
      popEmpty[f]   = (count[f] == '0) && bufEmpty[f] && !fillValid[f];
    end
    // The list is empty after this cycle's read as well as when already empty
    // In both cases the new entry becomes the head and no link is written
    pushToEmpty = (count[pushFifoId] == '0) ||
                  ((count[pushFifoId] == multiFifoPkg::countT'(1)) && readVec[pushFifoId]);
  end

  // Every push takes the offered free entry for its payload
  assign alloc      = pushValid;
  assign dataWrEn   = pushValid;
  assign dataWrAddr = allocAddr;
  assign dataWrData = pushData;

  // Link the new entry behind the old tail
  assign ptrWrEn   = pushValid && !pushToEmpty;
  assign ptrWrAddr = tail[pushFifoId];
  assign ptrWrData = allocAddr;

  // Data and next pointer of the granted head are read together
  assign rdEn      = |arbGrant;
  assign rdAddr    = head[grantId];
  assign arbUpdate = rdEn;
  assign fillAddr  = rdEntry;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int f = 0; f < numFifos; f++) begin
        head[f]  <= '0;
        tail[f]  <= '0;
        count[f] <= '0;
      end
      rdPending <= 1'b0;
      rdFifo    <= '0;
      rdEntry   <= '0;
      rdHasNext <= 1'b0;
    end else begin
      rdPending <= rdEn;
      rdFifo    <= grantId;
      rdEntry   <= head[grantId];
      // Only a list with older entries behind the head takes the returned pointer
      rdHasNext <= count[grantId] > multiFifoPkg::countT'(1);
      for (int f = 0; f < numFifos; f++) begin
        // A push and a read on one FIFO in the same cycle cancel out
        count[f] <= count[f] + multiFifoPkg::countT'(pushVec[f]) -
                    multiFifoPkg::countT'(readVec[f]);
        if (fillValid[f] && rdHasNext) begin
          head[f] <= ptrRdData;
        end
        if (pushVec[f]) begin
          tail[f] <= allocAddr;
          if (pushToEmpty) begin
            head[f] <= allocAddr;
          end
        end
      end
    end
  end

  // The external arbiter must pick at most one FIFO
  grantOneHotA: assert property (@(posedge clk) disable iff (!rstN)
    $onehot0(arbGrant));

  // A grant always answers a live request
  grantRequestedA: assert property (@(posedge clk) disable iff (!rstN)
    (arbGrant & ~arbRequest) == '0);

endmodule

//--- rtl/multiFifoTop.sv
// Shared-storage multi-FIFO
`timescale 1ns/1ns
`include "multiFifo_settings.svh"

module multiFifoTop (
  input  logic                                        clk,
  input  logic                                        rstN,
  input  logic                                        pushValid,
  input  multiFifoPkg::fifoIdT                        pushFifoId,
  input  multiFifoPkg::dataT                          pushData,
  output logic                                        pushCredit,
  output multiFifoPkg::fifoVecT                       popValid,
  input  multiFifoPkg::fifoVecT                       popReady,
  output multiFifoPkg::dataT [`MF_NUM_FIFOS-1:0]      popData,
  output multiFifoPkg::fifoVecT                       popEmpty
);

  // Free list handshake
  logic                  alloc;
  multiFifoMemPkg::addrT allocAddr;
  logic                  dealloc;
  multiFifoMemPkg::addrT deallocAddr;

  // RAM ports
  logic                  dataWrEn;
  multiFifoMemPkg::addrT dataWrAddr;
  multiFifoPkg::dataT    dataWrData;
  multiFifoPkg::dataT    dataRdData;
  logic                  ptrWrEn;
  multiFifoMemPkg::addrT ptrWrAddr;
  multiFifoMemPkg::ptrT  ptrWrData;
  multiFifoMemPkg::ptrT  ptrRdData;
  logic                  rdEn;
  multiFifoMemPkg::addrT rdAddr;

  // Pop-side scheduling
  multiFifoPkg::fifoVecT arbRequest;
  multiFifoPkg::fifoVecT arbGrant;
  logic                  arbUpdate;
  multiFifoPkg::fifoVecT fillValid;
  multiFifoMemPkg::addrT fillAddr;
  multiFifoPkg::fifoVecT bufFree;
  multiFifoPkg::fifoVecT deallocVec;
  multiFifoMemPkg::addrT deallocAddrVec [`MF_NUM_FIFOS];

  multiFifoCtrl i_ctrl (
    .clk, .rstN, .pushValid, .pushFifoId, .pushData, .allocAddr, .alloc,
    .dataWrEn, .dataWrAddr, .dataWrData, .ptrWrEn, .ptrWrAddr, .ptrWrData,
    .rdEn, .rdAddr, .ptrRdData, .arbRequest, .arbGrant, .arbUpdate,
    .bufFree, .bufEmpty(~popValid), .fillValid, .fillAddr, .popEmpty
  );

  freeList #(.depth(`MF_DEPTH)) i_freeList (
    .clk, .rstN, .alloc, .dealloc, .deallocAddr, .allocAddr, .pushCredit
  );

  syncRam #(.wordT(multiFifoPkg::dataT), .depth(`MF_DEPTH)) i_dataRam (
    .clk, .wrEn(dataWrEn), .wrAddr(dataWrAddr), .wrData(dataWrData),
    .rdEn, .rdAddr, .rdData(dataRdData)
  );

  syncRam #(.wordT(multiFifoMemPkg::ptrT), .depth(`MF_DEPTH)) i_ptrRam (
    .clk, .wrEn(ptrWrEn), .wrAddr(ptrWrAddr), .wrData(ptrWrData),
    .rdEn, .rdAddr, .rdData(ptrRdData)
  );

  // Kept outside the controller so the pop policy can be swapped
  rrArbiter #(.numReq(`MF_NUM_FIFOS)) i_arb (
    .clk, .rstN, .request(arbRequest), .update(arbUpdate), .grant(arbGrant)
  );

  // Every buffer sees the same read data and only the addressed one loads it
  for (genvar f = 0; f < `MF_NUM_FIFOS; f++) begin : gBuf
    stagingBuffer i_buf (
      .clk, .rstN, .fillValid(fillValid[f]), .fillData(dataRdData), .fillAddr,
      .popReady(popReady[f]), .popValid(popValid[f]), .popData(popData[f]),
      .free(bufFree[f]), .dealloc(deallocVec[f]), .deallocAddr(deallocAddrVec[f])
    );
  end

  // Select the one popping buffer for the single free list port
  always_comb begin
    dealloc     = |deallocVec;
    deallocAddr = '0;
    for (int f = 0; f < `MF_NUM_FIFOS; f++) begin
      if (deallocVec[f]) begin
        deallocAddr = deallocAddrVec[f];
      end
    end
  end

  // The free list returns one entry per cycle so pops must not coincide
  singlePopA: assert property (@(posedge clk) disable iff (!rstN)
    $onehot0(deallocVec));

endmodule

//--- bench/multiFifoTb.sv
// Multi-FIFO testbench
`timescale 1ns/1ns
`include "multiFifo_settings.svh"

module multiFifoTb;

  localparam int numFifos = `MF_NUM_FIFOS;
  localparam int depth = `MF_DEPTH;
  // Longest wait for any DUT event in clock cycles
  localparam int waitLimit = 200;

  logic                              clk = 1'b0;
  logic                              rstN;
  logic                              pushValid;
  multiFifoPkg::fifoIdT              pushFifoId;
  multiFifoPkg::dataT                pushData;
  logic                              pushCredit;
  multiFifoPkg::fifoVecT             popValid;
  multiFifoPkg::fifoVecT             popReady;
  multiFifoPkg::dataT [numFifos-1:0] popData;
  multiFifoPkg::fifoVecT             popEmpty;

  // Expected contents of every FIFO in push order
  multiFifoPkg::dataT model [numFifos][$];
  // Sender credit bookkeeping since reset
  int pushesMade = 0;
  int creditsReturned = 0;
  logic [15:0] lfsrState = 16'd58;

  multiFifoTop i_dut (
    .clk, .rstN, .pushValid, .pushFifoId, .pushData, .pushCredit,
    .popValid, .popReady, .popData, .popEmpty
  );

  always #2 clk = ~clk;

  // Each credit pulse is counted on the edge that ends it
  always @(posedge clk) begin
    if (rstN && pushCredit) begin
      creditsReturned <= creditsReturned + 1;
    end
  end

  // Fibonacci LFSR with taps 16 14 13 11, one step for each bit taken
  function automatic logic [31:0] randomBits(int n);
    logic [31:0] value;
    logic fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsrState[0]};
      fb = lfsrState[0] ^ lfsrState[2] ^ lfsrState[3] ^ lfsrState[5];
      lfsrState = {fb, lfsrState[15:1]};
    end
    return value;
  endfunction

  function automatic multiFifoPkg::fifoIdT randomId();
    return multiFifoPkg::fifoIdT'(randomBits($clog2(numFifos)));
  endfunction

  // Credits the sender holds right now
  function automatic int creditsHeld();
    return depth - pushesMade + creditsReturned;
  endfunction

  // Lowest FIFO that still has items in the model
  function automatic int busyFifo();
    for (int f = 0; f < numFifos; f++) begin
      if (model[f].size() > 0) begin
        return f;
      end
    end
    return 0;
  endfunction

  task automatic stopRun(string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic checkData(multiFifoPkg::dataT got, multiFifoPkg::dataT want, string what);
    if (got !== want) begin
      stopRun($sformatf("CHECK FAILED at %0t: %s, got %h want %h", $time, what, got, want));
    end
  endtask

  task automatic checkCount(multiFifoPkg::countT got, multiFifoPkg::countT want, string what);
    if (got !== want) begin
      stopRun($sformatf("CHECK FAILED at %0t: %s, got %0d want %0d", $time, what, got, want));
    end
  endtask

  task automatic checkFlags(multiFifoPkg::fifoVecT got, multiFifoPkg::fifoVecT want,
                            string what);
    if (got !== want) begin
      stopRun($sformatf("CHECK FAILED at %0t: %s, got %b want %b", $time, what, got, want));
    end
  endtask

  // One push, made only while a credit is held
  task automatic pushOne(multiFifoPkg::fifoIdT id, multiFifoPkg::dataT data);
    int waited;
    waited = 0;
    while (creditsHeld() <= 0) begin
      if (waited == waitLimit)
        stopRun("Timed out waiting for a push credit to come back");
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    pushValid  <= 1'b1;
    pushFifoId <= id;
    pushData   <= data;
    @(posedge clk);
    pushValid <= 1'b0;
    pushesMade++;
    model[id].push_back(data);
  endtask

  task automatic waitPopValid(int f);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!popValid[f]) begin
      if (waited == waitLimit)
        stopRun($sformatf("Timed out waiting for popValid on FIFO %0d", f));
      waited++;
      @(negedge clk);
    end
  endtask

  // Pop one item and expect its credit back exactly one cycle later
  task automatic popOne(int f);
    multiFifoPkg::dataT want;
    if (model[f].size() == 0)
      stopRun($sformatf("Test tried to pop FIFO %0d with nothing left in it", f));
    want = model[f].pop_front();
    waitPopValid(f);
    @(posedge clk);
    popReady <= multiFifoPkg::fifoVecT'(1) << f;
    @(negedge clk);
    checkData(popData[f], want, $sformatf("popData of FIFO %0d", f));
    @(posedge clk);
    popReady <= '0;
    @(negedge clk);
    checkCount(multiFifoPkg::countT'(pushCredit), 1, "credit pulse one cycle after pop");
    @(negedge clk);
    checkCount(multiFifoPkg::countT'(pushCredit), 0, "credit pulse longer than one cycle");
  endtask

  // With every popReady high each cycle of popValid is one transfer
  task automatic collectStream(int total);
    int got;
    int waited;
    got = 0;
    waited = 0;
    while (got < total) begin
      if (waited == waitLimit)
        stopRun("Timed out waiting for items to leave with every popReady high");
      @(negedge clk);
      waited++;
      for (int f = 0; f < numFifos; f++) begin
        if (popValid[f]) begin
          if (model[f].size() == 0)
            stopRun($sformatf("FIFO %0d delivered an item that was never pushed", f));
          checkData(popData[f], model[f].pop_front(), $sformatf("popData of FIFO %0d", f));
          got++;
          waited = 0;
        end
      end
    end
  endtask

  // Only one buffer is popped per cycle since the free list takes one entry back
  task automatic drainAll();
    for (int f = 0; f < numFifos; f++) begin
      while (model[f].size() > 0) begin
        popOne(f);
      end
    end
  endtask

  task automatic testReset();
    checkFlags(popEmpty, '1, "popEmpty after reset");
    checkFlags(popValid, '0, "popValid after reset");
    repeat (8) begin
      @(negedge clk);
      checkCount(multiFifoPkg::countT'(pushCredit), 0, "credit pulse without a pop");
    end
  endtask

  task automatic testSingleOrder();
    for (int i = 0; i < 6; i++) begin
      pushOne(2, randomBits(32));
    end
    drainAll();
  endtask

  // Every buffer is ready so items leave as soon as they reach it
  task automatic testInterleaved();
    @(posedge clk);
    popReady <= '1;
    fork
      for (int i = 0; i < 12; i++) begin
        pushOne(randomId(), randomBits(32));
      end
      collectStream(12);
    join
    @(posedge clk);
    popReady <= '0;
    // The last credit pulse ends one cycle after the last transfer
    repeat (2) @(negedge clk);
  endtask

  task automatic testFullAndCredit();
    checkCount(multiFifoPkg::countT'(creditsHeld()), depth, "credits before filling");
    for (int i = 0; i < depth; i++) begin
      pushOne(randomId(), randomBits(32));
    end
    checkCount(multiFifoPkg::countT'(creditsHeld()), 0, "credits with every entry in use");
    // Each returned credit is spent at once so freed entries get reused
    for (int i = 0; i < 4; i++) begin
      popOne(busyFifo());
      pushOne(randomId(), randomBits(32));
    end
    drainAll();
  endtask

  task automatic testBackPressure();
    localparam int stalled = 1;
    multiFifoPkg::fifoVecT stallMask;
    multiFifoPkg::dataT held;
    stallMask = multiFifoPkg::fifoVecT'(1) << stalled;
    for (int i = 0; i < 3 * numFifos; i++) begin
      pushOne(multiFifoPkg::fifoIdT'(i % numFifos), randomBits(32));
    end
    waitPopValid(stalled);
    checkFlags(popEmpty, '0, "popEmpty with items in every FIFO");
    held = popData[stalled];
    checkData(held, model[stalled][0], "head item of the stalled FIFO");
    for (int f = 0; f < numFifos; f++) begin
      while (f != stalled && model[f].size() > 0) begin
        popOne(f);
        checkFlags(popValid & stallMask, stallMask, "popValid of the stalled FIFO");
        checkData(popData[stalled], held, "popData of the stalled FIFO");
      end
    end
    drainAll();
  endtask

  task automatic testEmptyFlags();
    repeat (4) @(negedge clk);
    checkFlags(popEmpty, '1, "popEmpty after draining");
    checkFlags(popValid, '0, "popValid after draining");
    checkCount(multiFifoPkg::countT'(pushesMade - creditsReturned), 0,
               "pushes not matched by returned credits");
  endtask

  initial begin
    rstN       = 1'b0;
    pushValid  = 1'b0;
    pushFifoId = '0;
    pushData   = '0;
    popReady   = '0;
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    testReset();
    testSingleOrder();
    testInterleaved();
    testFullAndCredit();
    testBackPressure();
    testEmptyFlags();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
rtl/multiFifoPkg.sv
rtl/multiFifoMemPkg.sv
rtl/syncRam.sv
rtl/freeList.sv
rtl/rrArbiter.sv
rtl/stagingBuffer.sv
rtl/multiFifoCtrl.sv
rtl/multiFifoTop.sv
bench/multiFifoTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= multiFifoTb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "Simulation did not finish"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
